// ==== Makefile ====
BIN  := obj_dir/Vsense_monitor_tb
SRCS := $(wildcard hdl/*.sv bench/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): flist.f $(SRCS)
	verilator --binary --assert --timing -j 0 --top-module sense_monitor_tb -f flist.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/sense_monitor_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module sense_monitor_asserts (
  input wire logic                         gclk40,
  input wire logic                         hard_reset,
  input wire monitor_bus_pkg::wb_rsp_t     rsp_i,
  input wire monitor_adc_pkg::adc_sample_t sample_i
);

  import monitor_adc_pkg::*;

  int since_strb;
  int fail_overlap = 0;
  int fail_ack_len = 0;
  int fail_err_len = 0;
  int fail_spacing = 0;
  int fail_count;

  assign fail_count = fail_overlap + fail_ack_len + fail_err_len + fail_spacing;

  // cycles since the last strobe, saturating once the spacing is met.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      since_strb <= MIN_SAMPLE_SPACING;
    end else if (sample_i.strb) begin
      since_strb <= 1;
    end else if (since_strb < MIN_SAMPLE_SPACING) begin
      since_strb <= since_strb + 1;
    end
  end

  ack_err_exclusive: assert property (@(posedge gclk40) disable iff (!hard_reset)
    !(rsp_i.ack && rsp_i.err))
    else begin
      fail_overlap++;
      $error("ack and err asserted in the same cycle");
    end

  ack_single_cycle: assert property (@(posedge gclk40) disable iff (!hard_reset)
    rsp_i.ack |=> !rsp_i.ack)
    else begin
      fail_ack_len++;
      $error("ack held for more than one cycle");
    end

  err_single_cycle: assert property (@(posedge gclk40) disable iff (!hard_reset)
    rsp_i.err |=> !rsp_i.err)
    else begin
      fail_err_len++;
      $error("err held for more than one cycle");
    end

  strobe_spacing: assert property (@(posedge gclk40) disable iff (!hard_reset)
    sample_i.strb |-> since_strb >= MIN_SAMPLE_SPACING)
    else begin
      fail_spacing++;
      $error("sample strobes closer than the minimum spacing");
    end

endmodule

// the decoder sees no samples, so its strobe input is tied off.
bind bus_region_decode sense_monitor_asserts decode_asserts_inst (
  .gclk40     (gclk40),
  .hard_reset (hard_reset),
  .rsp_i      (wb_rsp_o),
  .sample_i   ('0)
);

bind level_checker sense_monitor_asserts levchk_asserts_inst (
  .gclk40     (gclk40),
  .hard_reset (hard_reset),
  .rsp_i      (bus_rsp_o),
  .sample_i   (sample_i)
);

`default_nettype wire

// ==== bench/sense_monitor_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sense_monitor_tb;

  import monitor_bus_pkg::*;
  import monitor_adc_pkg::*;

  localparam logic [BUS_ADDR_W-1:0] LC_BASE     = LEVCHK_BASE_DEFAULT;
  localparam logic [BUS_ADDR_W-1:0] VS_BASE     = VALS_BASE_DEFAULT;
  localparam logic [BUS_ADDR_W-1:0] STATUS_ADDR = LEVCHK_BASE_DEFAULT + 16'd130;
  localparam int unsigned           RAND_SEED   = 32'h0276_faf8;
  localparam int                    BUS_TIMEOUT = 40;

  logic                    gclk40;
  logic                    hard_reset;
  wb_req_t                 wb_req;
  wb_rsp_t                 wb_rsp;
  adc_sample_t             sample;
  logic                    monitor_en;
  lc_status_t              lc_status;
  logic [MAX_CHANNELS-1:0] v_in_range;

  // expected state, kept from the register map and the check rules.
  logic [ADC_RESULT_W-1:0] exp_thresh [4*MAX_CHANNELS];
  logic [MAX_CHANNELS-1:0] exp_range;
  lc_status_t              exp_status;
  int                      errors;
  int                      checks;
  int                      tests;

  sense_monitor_top #(
    .NUM_CHANNELS (MAX_CHANNELS),
    .LEVCHK_BASE  (LC_BASE),
    .VALS_BASE    (VS_BASE)
  ) sense_monitor_top_inst (
    .gclk40       (gclk40),
    .hard_reset   (hard_reset),
    .wb_req_i     (wb_req),
    .wb_rsp_o     (wb_rsp),
    .sample_i     (sample),
    .monitor_en_i (monitor_en),
    .lc_status_o  (lc_status),
    .v_in_range_o (v_in_range)
  );

  initial begin
    gclk40 = 1'b0;
    forever #5 gclk40 = ~gclk40;
  end

  task automatic check_rsp(input wb_rsp_t got, input wb_rsp_t exp, input bit cmp_dat,
                           input string what);
    checks++;
    if (got.ack !== exp.ack || got.err !== exp.err || (cmp_dat && got.dat !== exp.dat)) begin
      errors++;
      $display("Fail at %0t: %s, got ack=%b err=%b dat=%h, expected ack=%b err=%b dat=%h",
               $time, what, got.ack, got.err, got.dat, exp.ack, exp.err, exp.dat);
    end
  endtask

  task automatic check_status(input lc_status_t got, input lc_status_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s, status %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_range(input logic [MAX_CHANNELS-1:0] got,
                             input logic [MAX_CHANNELS-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s, in-range %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one bus cycle; the request is held until ack or err shows up.
  task automatic bus_access(input logic we, input logic [BUS_ADDR_W-1:0] adr,
                            input logic [BUS_DATA_W-1:0] dat, output wb_rsp_t rsp);
    int waited;
    rsp    = '0;
    waited = 0;
    @(negedge gclk40);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do begin
      @(negedge gclk40);
      waited++;
    end while (!(wb_rsp.ack || wb_rsp.err) && waited < BUS_TIMEOUT);
    if (wb_rsp.ack || wb_rsp.err) begin
      rsp = wb_rsp;
    end else begin
      errors++;
      $display("Bus access to address %h got neither ack nor err in %0d cycles", adr, waited);
    end
    wb_req = '0;
  endtask

  task automatic bus_write(input logic [BUS_ADDR_W-1:0] adr, input logic [BUS_DATA_W-1:0] dat);
    wb_rsp_t rsp;
    bus_access(1'b1, adr, dat, rsp);
    check_rsp(rsp, wb_rsp_t'{dat: '0, ack: 1'b1, err: 1'b0}, 1'b0, "write acknowledge");
  endtask

  task automatic read_expect(input logic [BUS_ADDR_W-1:0] adr, input logic [BUS_DATA_W-1:0] dat,
                             input string what);
    wb_rsp_t rsp;
    bus_access(1'b0, adr, '0, rsp);
    check_rsp(rsp, wb_rsp_t'{dat: dat, ack: 1'b1, err: 1'b0}, 1'b1, what);
  endtask

  task automatic write_thresh(input logic [1:0] kind, input logic [ADC_CHANNEL_W-1:0] ch,
                              input logic [ADC_RESULT_W-1:0] value);
    exp_thresh[{kind, ch}] = value;
    bus_write(LC_BASE + BUS_ADDR_W'({kind, ch}), BUS_DATA_W'(value));
  endtask

  task automatic set_windows(input logic [ADC_CHANNEL_W-1:0] ch,
                             input logic [ADC_RESULT_W-1:0] sl, input logic [ADC_RESULT_W-1:0] sh,
                             input logic [ADC_RESULT_W-1:0] hl, input logic [ADC_RESULT_W-1:0] hh);
    write_thresh(THRESH_SOFT_LOW, ch, sl);
    write_thresh(THRESH_SOFT_HIGH, ch, sh);
    write_thresh(THRESH_HARD_LOW, ch, hl);
    write_thresh(THRESH_HARD_HIGH, ch, hh);
  endtask

  task automatic drive_monitor_en(input logic en);
    @(negedge gclk40);
    monitor_en = en;
  endtask

  // the outputs must hold through the fifth edge and change on the sixth.
  task automatic sample_and_check(input logic [ADC_CHANNEL_W-1:0] ch,
                                  input logic [ADC_RESULT_W-1:0] res);
    logic hard_out;
    hard_out = (res < exp_thresh[{THRESH_HARD_LOW, ch}]) ||
               (res > exp_thresh[{THRESH_HARD_HIGH, ch}]);
    @(negedge gclk40);
    sample = '{strb: 1'b1, channel: ch, result: res};
    @(negedge gclk40);
    sample.strb = 1'b0;
    repeat (4) @(negedge gclk40);
    check_range(v_in_range, exp_range, "in-range vector before the sixth edge");
    check_status(lc_status, exp_status, "status before the sixth edge");
    @(negedge gclk40);
    exp_range[ch] = (res >= exp_thresh[{THRESH_SOFT_LOW, ch}]) &&
                    (res <= exp_thresh[{THRESH_SOFT_HIGH, ch}]);
    if (monitor_en && !exp_range[ch]) begin
      exp_status.soft_viol = 1'b1;
    end
    if (monitor_en && hard_out) begin
      exp_status.hard_viol = 1'b1;
    end
    check_range(v_in_range, exp_range, "in-range vector after the sample");
    check_status(lc_status, exp_status, "status after the sample");
    repeat (2) @(negedge gclk40);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("test %s finished with %0d errors", name, errors - errs_before);
  endtask

  task automatic test_thresh_readback();
    int                       errs_before;
    logic [ADC_CHANNEL_W-1:0] ch [4];
    errs_before = errors;
    foreach (ch[i]) begin
      ch[i] = ADC_CHANNEL_W'($urandom_range(0, MAX_CHANNELS - 1));
      for (int k = 0; k < 4; k++) begin
        write_thresh(2'(k), ch[i], ADC_RESULT_W'($urandom_range(0, 4095)));
      end
    end
    foreach (ch[i]) begin
      for (int k = 0; k < 4; k++) begin
        read_expect(LC_BASE + BUS_ADDR_W'({2'(k), ch[i]}),
                    BUS_DATA_W'(exp_thresh[{2'(k), ch[i]}]), "threshold readback");
      end
    end
    report_test("threshold_readback", errs_before);
  endtask

  task automatic test_in_range();
    int errs_before;
    errs_before = errors;
    set_windows(5'd3, 12'd1000, 12'd3000, 12'd500, 12'd3500);
    drive_monitor_en(1'b1);
    sample_and_check(5'd3, 12'd2000);
    read_expect(VS_BASE + 16'd3, 16'd2000, "latest value of channel 3");
    read_expect(LC_BASE + 16'd128, exp_range[15:0], "in-range vector low half");
    read_expect(LC_BASE + 16'd129, exp_range[31:16], "in-range vector high half");
    report_test("in_range_sample", errs_before);
  endtask

  task automatic test_soft_clear();
    int errs_before;
    errs_before = errors;
    set_windows(5'd5, 12'd1000, 12'd3000, 12'd500, 12'd3500);
    sample_and_check(5'd5, 12'd3200);
    check_status(lc_status, lc_status_t'{hard_viol: 1'b0, soft_viol: 1'b1},
                 "soft violation raised");
    bus_write(STATUS_ADDR, 16'h0001);
    exp_status.soft_viol = 1'b0;
    check_status(lc_status, exp_status, "soft violation cleared");
    report_test("soft_violation_clear", errs_before);
  endtask

  task automatic test_hard_gating();
    int errs_before;
    errs_before = errors;
    set_windows(5'd9, 12'd1000, 12'd3000, 12'd500, 12'd3500);
    sample_and_check(5'd9, 12'd2000);
    drive_monitor_en(1'b0);
    sample_and_check(5'd9, 12'd100);
    drive_monitor_en(1'b1);
    sample_and_check(5'd9, 12'd100);
    check_status(lc_status, lc_status_t'{hard_viol: 1'b1, soft_viol: 1'b1},
                 "both violations raised");
    read_expect(STATUS_ADDR, BUS_DATA_W'(exp_status), "status register readback");
    bus_write(STATUS_ADDR, 16'h0003);
    exp_status = '0;
    check_status(lc_status, exp_status, "both violations cleared");
    report_test("hard_violation_gating", errs_before);
  endtask

  task automatic test_peak();
    int                      errs_before;
    logic [ADC_RESULT_W-1:0] res;
    logic [ADC_RESULT_W-1:0] peak;
    errs_before = errors;
    peak        = '0;
    res         = '0;
    set_windows(5'd12, 12'd0, 12'd4095, 12'd0, 12'd4095);
    repeat (6) begin
      res = ADC_RESULT_W'($urandom_range(0, 4095));
      sample_and_check(5'd12, res);
      if (res > peak) begin
        peak = res;
      end
    end
    read_expect(VS_BASE + 16'd44, BUS_DATA_W'(peak), "peak of channel 12");
    read_expect(VS_BASE + 16'd12, BUS_DATA_W'(res), "latest value of channel 12");
    bus_write(VS_BASE + 16'd44, 16'hffff);
    read_expect(VS_BASE + 16'd44, 16'd0, "peak of channel 12 after clear");
    report_test("peak_tracking", errs_before);
  endtask

  task automatic test_unmapped();
    int      errs_before;
    wb_rsp_t rsp;
    errs_before = errors;
    bus_access(1'b0, 16'h0400, '0, rsp);
    check_rsp(rsp, wb_rsp_t'{dat: '0, ack: 1'b0, err: 1'b1}, 1'b0, "read outside both regions");
    bus_access(1'b1, 16'h0000, 16'h1234, rsp);
    check_rsp(rsp, wb_rsp_t'{dat: '0, ack: 1'b0, err: 1'b1}, 1'b0, "write outside both regions");
    bus_access(1'b0, VS_BASE + 16'd64, '0, rsp);
    check_rsp(rsp, wb_rsp_t'{dat: '0, ack: 1'b0, err: 1'b1}, 1'b0, "read past the value store");
    read_expect(LC_BASE + 16'd200, 16'd0, "unused level checker offset");
    report_test("unmapped_address", errs_before);
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    errors     = 0;
    checks     = 0;
    tests      = 0;
    hard_reset = 1'b0;
    wb_req     = '0;
    sample     = '0;
    monitor_en = 1'b0;
    exp_range  = '0;
    exp_status = '0;
    repeat (3) @(negedge gclk40);
    hard_reset = 1'b1;
    check_rsp(wb_rsp, '0, 1'b1, "bus response after reset");
    check_range(v_in_range, '0, "in-range vector after reset");
    check_status(lc_status, '0, "status after reset");
    test_thresh_readback();
    test_in_range();
    test_soft_clear();
    test_hard_gating();
    test_peak();
    test_unmapped();
    // failed bound assertions count as errors of the run.
    errors += sense_monitor_top_inst.bus_region_decode_inst.decode_asserts_inst.fail_count;
    errors += sense_monitor_top_inst.level_checker_inst.levchk_asserts_inst.fail_count;
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/monitor_bus_pkg.sv
hdl/monitor_adc_pkg.sv
hdl/level_checker.sv
hdl/value_store.sv
hdl/bus_region_decode.sv
hdl/sense_monitor_top.sv
bench/sense_monitor_asserts.sv
bench/sense_monitor_tb.sv

// ==== hdl/bus_region_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_region_decode #(
  parameter logic [monitor_bus_pkg::BUS_ADDR_W-1:0] LEVCHK_BASE = 16'h0000,
  parameter logic [monitor_bus_pkg::BUS_ADDR_W-1:0] VALS_BASE   = 16'h0100
) (
  input  wire logic                     gclk40,
  input  wire logic                     hard_reset,
  input  wire monitor_bus_pkg::wb_req_t wb_req_i,
  output monitor_bus_pkg::wb_req_t      levchk_req_o,
  input  wire monitor_bus_pkg::wb_rsp_t levchk_rsp_i,
  output monitor_bus_pkg::wb_req_t      vals_req_o,
  input  wire monitor_bus_pkg::wb_rsp_t vals_rsp_i,
  output monitor_bus_pkg::wb_rsp_t      wb_rsp_o
);

  import monitor_bus_pkg::*;

  region_e               region;
  logic [BUS_ADDR_W-1:0] levchk_offs;
  logic [BUS_ADDR_W-1:0] vals_offs;
  logic                  err_q;

  // subtracting first keeps the upper bound check free of overflow near the top.
  assign levchk_offs = wb_req_i.adr - LEVCHK_BASE;
  assign vals_offs   = wb_req_i.adr - VALS_BASE;

  always_comb begin
    if ((wb_req_i.adr >= LEVCHK_BASE) && (32'(levchk_offs) < LEVCHK_WORDS)) begin
      region = REGION_LEVCHK;
    end else if ((wb_req_i.adr >= VALS_BASE) && (32'(vals_offs) < VALS_WORDS)) begin
      region = REGION_VALS;
    end else begin
      region = REGION_NONE;
    end
  end

  // cyc and the write data go to both slaves; only stb is steered.
  always_comb begin
    levchk_req_o     = wb_req_i;
    levchk_req_o.stb = wb_req_i.stb && (region == REGION_LEVCHK);
    levchk_req_o.adr = BUS_ADDR_W'(levchk_offs[REGION_SPAN_W-1:0]);

    vals_req_o       = wb_req_i;
    vals_req_o.stb   = wb_req_i.stb && (region == REGION_VALS);
    vals_req_o.adr   = BUS_ADDR_W'(vals_offs[REGION_SPAN_W-1:0]);
  end

  // unmapped accesses get a single err pulse, one cycle after stb.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      err_q <= 1'b0;
    end else begin
      err_q <= wb_req_i.cyc && wb_req_i.stb && (region == REGION_NONE) && !err_q;
    end
  end

  // slaves return zero data when idle, so a plain OR merges them.
  always_comb begin
    wb_rsp_o.dat = levchk_rsp_i.dat | vals_rsp_i.dat;
    wb_rsp_o.ack = levchk_rsp_i.ack | vals_rsp_i.ack;
    wb_rsp_o.err = levchk_rsp_i.err | vals_rsp_i.err | err_q;
  end

endmodule

`default_nettype wire

// ==== hdl/level_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module level_checker #(
  parameter int NUM_CHANNELS = monitor_adc_pkg::MAX_CHANNELS
) (
  input  wire logic                                gclk40,
  input  wire logic                                hard_reset,
  input  wire monitor_bus_pkg::wb_req_t            bus_req_i,
  output monitor_bus_pkg::wb_rsp_t                 bus_rsp_o,
  input  wire monitor_adc_pkg::adc_sample_t        sample_i,
  input  wire logic                                monitor_en_i,
  output monitor_adc_pkg::lc_status_t              lc_status_o,
  output logic [monitor_adc_pkg::MAX_CHANNELS-1:0] v_in_range_o
);

  import monitor_bus_pkg::*;
  import monitor_adc_pkg::*;

  localparam int THRESH_DEPTH = 4 * MAX_CHANNELS;
  localparam int THRESH_AW    = 2 + ADC_CHANNEL_W;

  localparam logic [REGION_SPAN_W-1:0] OFFS_VEC_LO = 8'd128;
  localparam logic [REGION_SPAN_W-1:0] OFFS_VEC_HI = 8'd129;
  localparam logic [REGION_SPAN_W-1:0] OFFS_STATUS = 8'd130;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_FETCH,
    SEQ_COMPARE
  } seq_state_e;

  logic [ADC_RESULT_W-1:0]  thresh_mem [THRESH_DEPTH];
  logic [THRESH_AW-1:0]     rd_addr;
  logic [ADC_RESULT_W-1:0]  rd_data;

  seq_state_e               state;
  thresh_kind_e             fetch_kind;
  logic [ADC_CHANNEL_W-1:0] cur_channel;
  logic [ADC_RESULT_W-1:0]  cur_result;
  logic [ADC_RESULT_W-1:0]  soft_low;
  logic [ADC_RESULT_W-1:0]  soft_high;
  logic [ADC_RESULT_W-1:0]  hard_low;
  logic                     soft_in;
  logic                     hard_in;
  logic                     sample_ok;

  logic [REGION_SPAN_W-1:0] offset;
  logic                     bus_valid;
  logic                     thresh_sel;
  logic                     thresh_rd_start;
  logic                     rd_pend;
  logic                     reg_access;
  logic                     status_clr;
  logic [BUS_DATA_W-1:0]    reg_rdata;

  assign sample_ok = sample_i.strb && (32'(sample_i.channel) < NUM_CHANNELS);

  assign offset     = bus_req_i.adr[REGION_SPAN_W-1:0];
  assign thresh_sel = offset < REGION_SPAN_W'(THRESH_DEPTH);

  // a second access starts only after the ack cycle has passed.
  assign bus_valid = bus_req_i.cyc && bus_req_i.stb && !bus_rsp_o.ack && !rd_pend;

  // threshold reads need the shared read port, so they wait for an idle sequencer.
  assign thresh_rd_start = bus_valid && thresh_sel && !bus_req_i.we && (state == SEQ_IDLE);
  assign reg_access      = bus_valid && !(thresh_sel && !bus_req_i.we);
  assign status_clr      = reg_access && bus_req_i.we && (offset == OFFS_STATUS);

  // the sequencer owns the read port while it fetches a channel's thresholds.
  assign rd_addr = (state == SEQ_FETCH) ? {fetch_kind, cur_channel} : offset[THRESH_AW-1:0];

  always_ff @(posedge gclk40) begin
    if (reg_access && thresh_sel && bus_req_i.we) begin
      thresh_mem[offset[THRESH_AW-1:0]] <= bus_req_i.dat[ADC_RESULT_W-1:0];
    end
    rd_data <= thresh_mem[rd_addr];
  end

  always_comb begin
    case (offset)
      OFFS_VEC_LO: reg_rdata = v_in_range_o[BUS_DATA_W-1:0];
      OFFS_VEC_HI: reg_rdata = v_in_range_o[MAX_CHANNELS-1:BUS_DATA_W];
      OFFS_STATUS: reg_rdata = {{(BUS_DATA_W-2){1'b0}}, lc_status_o};
      default:     reg_rdata = '0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      bus_rsp_o <= '0;
      rd_pend   <= 1'b0;
    end else begin
      bus_rsp_o <= '0;
      rd_pend   <= thresh_rd_start;
      if (rd_pend) begin
        bus_rsp_o.ack <= 1'b1;
        bus_rsp_o.dat <= BUS_DATA_W'(rd_data);
      end else if (reg_access) begin
        bus_rsp_o.ack <= 1'b1;
        bus_rsp_o.dat <= bus_req_i.we ? '0 : reg_rdata;
      end
    end
  end

  // latch, then walk the four kinds; the compare state follows the last fetch.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      state      <= SEQ_IDLE;
      fetch_kind <= THRESH_SOFT_LOW;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (sample_ok) begin
            state      <= SEQ_FETCH;
            fetch_kind <= THRESH_SOFT_LOW;
          end
        end
        SEQ_FETCH: begin
          fetch_kind <= thresh_kind_e'(fetch_kind + 2'd1);
          if (fetch_kind == THRESH_HARD_HIGH) begin
            state <= SEQ_COMPARE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // rd_data lags the fetch address by one cycle, so each edge stores the previous kind.
  always_ff @(posedge gclk40) begin
    if (state == SEQ_IDLE && sample_ok) begin
      cur_channel <= sample_i.channel;
      cur_result  <= sample_i.result;
    end
    if (state == SEQ_FETCH) begin
      case (fetch_kind)
        THRESH_SOFT_HIGH: soft_low  <= rd_data;
        THRESH_HARD_LOW:  soft_high <= rd_data;
        THRESH_HARD_HIGH: hard_low  <= rd_data;
        default:          ;
      endcase
    end
  end

  // the hard high threshold is still in rd_data during the compare cycle.
  assign soft_in = (cur_result >= soft_low) && (cur_result <= soft_high);
  assign hard_in = (cur_result >= hard_low) && (cur_result <= rd_data);

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      lc_status_o  <= '0;
      v_in_range_o <= '0;
    end else begin
      if (status_clr) begin
        lc_status_o.soft_viol <= lc_status_o.soft_viol && !bus_req_i.dat[0];
        lc_status_o.hard_viol <= lc_status_o.hard_viol && !bus_req_i.dat[1];
      end
      // a new violation in the same cycle wins over the clear.
      if (state == SEQ_COMPARE) begin
        v_in_range_o[cur_channel] <= soft_in;
        if (monitor_en_i && !soft_in) begin
          lc_status_o.soft_viol <= 1'b1;
        end
        if (monitor_en_i && !hard_in) begin
          lc_status_o.hard_viol <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/monitor_adc_pkg.sv ====
`default_nettype none

package monitor_adc_pkg;

  localparam int ADC_RESULT_W  = 12;
  localparam int ADC_CHANNEL_W = 5;
  localparam int MAX_CHANNELS  = 32;

  // the sample source guarantees at least this many cycles between strobes.
  localparam int MIN_SAMPLE_SPACING = 8;

  // one converted sample, valid for the single cycle that strb is high.
  typedef struct packed {
    logic                     strb;
    logic [ADC_CHANNEL_W-1:0] channel;
    logic [ADC_RESULT_W-1:0]  result;
  } adc_sample_t;

  // threshold kind, which is also bits 6:5 of the threshold offset.
  typedef enum logic [1:0] {
    THRESH_SOFT_LOW  = 2'd0,
    THRESH_SOFT_HIGH = 2'd1,
    THRESH_HARD_LOW  = 2'd2,
    THRESH_HARD_HIGH = 2'd3
  } thresh_kind_e;

  // ordered so the soft flag lands on bit 0, as in the status register.
  typedef struct packed {
    logic hard_viol;
    logic soft_viol;
  } lc_status_t;

endpackage

`default_nettype wire

// ==== hdl/monitor_bus_pkg.sv ====
`default_nettype none

package monitor_bus_pkg;

  // bus geometry shared by the master port and every slave.
  localparam int BUS_ADDR_W = 16;
  localparam int BUS_DATA_W = 16;

  // slaves only see the offset inside their own region.
  localparam int REGION_SPAN_W = 8;

  // address map defaults, overridable from the top level.
  localparam logic [BUS_ADDR_W-1:0] LEVCHK_BASE_DEFAULT = 16'h0100;
  localparam logic [BUS_ADDR_W-1:0] VALS_BASE_DEFAULT   = 16'h0200;

  // region sizes in words.
  localparam int LEVCHK_WORDS = 256;
  localparam int VALS_WORDS   = 64;

  // master request, held stable by the master until ack or err.
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [BUS_ADDR_W-1:0] adr;
    logic [BUS_DATA_W-1:0] dat;
  } wb_req_t;

  // slave response; dat is zero whenever ack is low so responses can be ORed.
  typedef struct packed {
    logic [BUS_DATA_W-1:0] dat;
    logic                  ack;
    logic                  err;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    REGION_LEVCHK,
    REGION_VALS,
    REGION_NONE
  } region_e;

endpackage

`default_nettype wire

// ==== hdl/sense_monitor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sense_monitor_top #(
  parameter int NUM_CHANNELS = monitor_adc_pkg::MAX_CHANNELS,
  parameter logic [monitor_bus_pkg::BUS_ADDR_W-1:0] LEVCHK_BASE =
    monitor_bus_pkg::LEVCHK_BASE_DEFAULT,
  parameter logic [monitor_bus_pkg::BUS_ADDR_W-1:0] VALS_BASE =
    monitor_bus_pkg::VALS_BASE_DEFAULT
) (
  input  wire logic                                gclk40,
  input  wire logic                                hard_reset,
  input  wire monitor_bus_pkg::wb_req_t            wb_req_i,
  output monitor_bus_pkg::wb_rsp_t                 wb_rsp_o,
  input  wire monitor_adc_pkg::adc_sample_t        sample_i,
  input  wire logic                                monitor_en_i,
  output monitor_adc_pkg::lc_status_t              lc_status_o,
  output logic [monitor_adc_pkg::MAX_CHANNELS-1:0] v_in_range_o
);

  import monitor_bus_pkg::*;

  wb_req_t levchk_req;
  wb_rsp_t levchk_rsp;
  wb_req_t vals_req;
  wb_rsp_t vals_rsp;

  bus_region_decode #(
    .LEVCHK_BASE (LEVCHK_BASE),
    .VALS_BASE   (VALS_BASE)
  ) bus_region_decode_inst (
    .gclk40       (gclk40),
    .hard_reset   (hard_reset),
    .wb_req_i     (wb_req_i),
    .levchk_req_o (levchk_req),
    .levchk_rsp_i (levchk_rsp),
    .vals_req_o   (vals_req),
    .vals_rsp_i   (vals_rsp),
    .wb_rsp_o     (wb_rsp_o)
  );

  // both slaves see every sample; neither can stall the source.
  level_checker #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) level_checker_inst (
    .gclk40       (gclk40),
    .hard_reset   (hard_reset),
    .bus_req_i    (levchk_req),
    .bus_rsp_o    (levchk_rsp),
    .sample_i     (sample_i),
    .monitor_en_i (monitor_en_i),
    .lc_status_o  (lc_status_o),
    .v_in_range_o (v_in_range_o)
  );

  value_store #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) value_store_inst (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .bus_req_i  (vals_req),
    .bus_rsp_o  (vals_rsp),
    .sample_i   (sample_i)
  );

endmodule

`default_nettype wire

// ==== hdl/value_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module value_store #(
  parameter int NUM_CHANNELS = monitor_adc_pkg::MAX_CHANNELS
) (
  input  wire logic                         gclk40,
  input  wire logic                         hard_reset,
  input  wire monitor_bus_pkg::wb_req_t     bus_req_i,
  output monitor_bus_pkg::wb_rsp_t          bus_rsp_o,
  input  wire monitor_adc_pkg::adc_sample_t sample_i
);

  import monitor_bus_pkg::*;
  import monitor_adc_pkg::*;

  logic [ADC_RESULT_W-1:0]  latest_q [NUM_CHANNELS];
  logic [ADC_RESULT_W-1:0]  peak_q [NUM_CHANNELS];

  logic [REGION_SPAN_W-1:0] offset;
  logic [ADC_CHANNEL_W-1:0] bus_ch;
  logic                     peak_sel;
  logic                     bus_ch_ok;
  logic                     bus_valid;
  logic                     peak_clr;
  logic [BUS_DATA_W-1:0]    rdata;

  // offsets 0..31 are latest values, 32..63 the peaks; bit 5 picks the bank.
  assign offset    = bus_req_i.adr[REGION_SPAN_W-1:0];
  assign bus_ch    = offset[ADC_CHANNEL_W-1:0];
  assign peak_sel  = offset[ADC_CHANNEL_W];
  assign bus_ch_ok = (offset[REGION_SPAN_W-1:ADC_CHANNEL_W+1] == '0) &&
                     (32'(bus_ch) < NUM_CHANNELS);

  assign bus_valid = bus_req_i.cyc && bus_req_i.stb && !bus_rsp_o.ack;
  assign peak_clr  = bus_valid && bus_req_i.we && peak_sel && bus_ch_ok;

  always_comb begin
    if (!bus_ch_ok) begin
      rdata = '0;
    end else if (peak_sel) begin
      rdata = BUS_DATA_W'(peak_q[bus_ch]);
    end else begin
      rdata = BUS_DATA_W'(latest_q[bus_ch]);
    end
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        latest_q[ch] <= '0;
        peak_q[ch]   <= '0;
      end
    end else begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        if (sample_i.strb && (32'(sample_i.channel) == ch)) begin
          latest_q[ch] <= sample_i.result;
          if (sample_i.result > peak_q[ch]) begin
            peak_q[ch] <= sample_i.result;
          end
        end
        // a clear from the bus overrides a sample on the same edge.
        if (peak_clr && (32'(bus_ch) == ch)) begin
          peak_q[ch] <= '0;
        end
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      bus_rsp_o <= '0;
    end else begin
      bus_rsp_o <= '0;
      if (bus_valid) begin
        bus_rsp_o.ack <= 1'b1;
        bus_rsp_o.dat <= bus_req_i.we ? '0 : rdata;
      end
    end
  end

endmodule

`default_nettype wire
